//--- build.f
+incdir+design
design/sq_pkg.sv
design/sq_dispatch.sv
design/sq_entry.sv
design/sq_issue.sv
design/store_queue.sv
testbench/store_queue_tb.sv

//--- design/sq_config.svh
`ifndef SQ_CONFIG_SVH
`define SQ_CONFIG_SVH

// Queue depth, at least 2
`define SQ_ENTRIES	8

// Physical register file size, sets the CDB tag width
`define PRF_SIZE	64

// Reorder buffer size, rob index carries one extra bit
`define ROB_SIZE	32

`endif

//--- design/sq_dispatch.sv
`timescale 1ns/100ps

module sq_dispatch import sq_pkg::*; (
	input								clock,
	input								reset,
	input								flush,
	input	sq_dispatch_t				dispatch [2],
	input			[ENTRIES-1:0]		busy,
	input			[ENTRIES-1:0]		free,
	output logic	[ENTRIES-1:0]		write,
	output sq_dispatch_t				write_payload [ENTRIES],
	output logic						room
);

	localparam int CNT_W = $clog2(ENTRIES + 1);

	logic							first_found;
	logic							second_found;
	logic	[SQ_IDX_W-1:0]			first_idx;
	logic	[SQ_IDX_W-1:0]			second_idx;
	logic	[SQ_IDX_W-1:0]			slot1_idx;
	logic	[ENTRIES-1:0]			next_busy;
	logic	[CNT_W-1:0]				free_count;

	// Lowest two free entries
	always_comb begin
		first_found		= 1'b0;
		second_found	= 1'b0;
		first_idx		= '0;
		second_idx		= '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (!busy[i]) begin
				if (!first_found) begin
					first_found	= 1'b1;
					first_idx	= SQ_IDX_W'(i);
				end else if (!second_found) begin
					second_found	= 1'b1;
					second_idx		= SQ_IDX_W'(i);
				end
			end
		end
	end

	// Slot 1 moves down when slot 0 is empty
	assign slot1_idx = dispatch[0].valid ? second_idx : first_idx;

	always_comb begin
		write = '0;
		for (int i = 0; i < ENTRIES; i++)
			write_payload[i] = (dispatch[1].valid && slot1_idx == SQ_IDX_W'(i)) ?
				dispatch[1] : dispatch[0];
		if (dispatch[0].valid && first_found)
			write[first_idx] = 1'b1;
		if (dispatch[1].valid && (dispatch[0].valid ? second_found : first_found))
			write[slot1_idx] = 1'b1;
	end

	// Occupancy after this edge, flush wins over everything
	always_comb begin
		next_busy	= flush ? '0 : ((busy & ~free) | write);
		free_count	= '0;
		for (int i = 0; i < ENTRIES; i++) begin
			if (!next_busy[i])
				free_count = free_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset)
			room <= 1'b1;
		else
			room <= (free_count >= 2);	// Room for a full two-wide dispatch
	end

endmodule

//--- design/sq_entry.sv
`timescale 1ns/100ps

module sq_entry import sq_pkg::*; (
	input							clock,
	input							reset,
	input							flush,
	input							write,
	input	sq_dispatch_t			write_payload,
	input							free,
	input	sq_cdb_t				cdb [2],
	output	sq_entry_view_t			view
);

	logic					busy, next_busy;
	logic					base_ready, next_base_ready;
	logic					data_ready, next_data_ready;
	logic	[ROB_W-1:0]		rob_idx, next_rob_idx;
	logic	[63:0]			imm, next_imm;
	sq_operand_u			base, next_base;
	sq_operand_u			data, next_data;

	always_ff @(posedge clock) begin
		if (reset) begin
			busy		<= 1'b0;
			base_ready	<= 1'b0;
			data_ready	<= 1'b0;
		end else begin
			busy		<= next_busy;
			base_ready	<= next_base_ready;
			data_ready	<= next_data_ready;
		end
	end

	always_ff @(posedge clock) begin
		rob_idx	<= next_rob_idx;
		imm		<= next_imm;
		base	<= next_base;
		data	<= next_data;
	end

	always_comb begin
		next_busy		= busy;
		next_base_ready	= base_ready;
		next_data_ready	= data_ready;
		next_rob_idx	= rob_idx;
		next_imm		= imm;
		next_base		= base;
		next_data		= data;
		if (flush) begin
			next_busy		= 1'b0;
			next_base_ready	= 1'b0;
			next_data_ready	= 1'b0;
		end else if (free) begin
			next_busy		= 1'b0;		// Memory took the write
			next_base_ready	= 1'b0;
			next_data_ready	= 1'b0;
		end else if (write) begin
			next_busy		= 1'b1;
			next_rob_idx	= write_payload.rob_idx;
			next_imm		= write_payload.imm;
			next_base		= write_payload.base;
			next_base_ready	= write_payload.base_ready;
			next_data		= write_payload.data;
			next_data_ready	= write_payload.data_ready;
		end else if (busy) begin
			// Later bus overrides, so CDB 1 wins on a shared tag
			for (int c = 0; c < 2; c++) begin
				if (cdb[c].valid && !base_ready && cdb[c].tag == base.tag_view.tag) begin
					next_base.value	= cdb[c].value;
					next_base_ready	= 1'b1;
				end
				if (cdb[c].valid && !data_ready && cdb[c].tag == data.tag_view.tag) begin
					next_data.value	= cdb[c].value;
					next_data_ready	= 1'b1;
				end
			end
		end
	end

	// Operand words are only meaningful as values once ready
	assign view.busy	= busy;
	assign view.ready	= busy && base_ready && data_ready;
	assign view.rob_idx	= rob_idx;
	assign view.imm		= imm;
	assign view.base	= base.value;
	assign view.data	= data.value;

endmodule

//--- design/sq_issue.sv
`timescale 1ns/100ps

module sq_issue import sq_pkg::*; (
	input								clock,
	input								reset,
	input	sq_entry_view_t				view [ENTRIES],
	input								mem_ready,
	output logic						mem_valid,
	output sq_mem_req_t					mem_req,
	output logic	[ENTRIES-1:0]		free
);

	logic						stalled;
	logic	[SQ_IDX_W-1:0]		stalled_idx;
	logic						stall_hit;
	logic						found;
	logic	[SQ_IDX_W-1:0]		pick;

	// A request refused last cycle keeps its entry until memory takes it
	assign stall_hit = stalled && view[stalled_idx].busy && view[stalled_idx].ready;

	always_comb begin
		found	= 1'b0;
		pick	= '0;
		for (int i = ENTRIES - 1; i >= 0; i--) begin
			if (view[i].busy && view[i].ready) begin
				found	= 1'b1;
				pick	= SQ_IDX_W'(i);		// Lowest index wins
			end
		end
		if (stall_hit)
			pick = stalled_idx;
	end

	assign mem_valid		= found;
	assign mem_req.addr		= view[pick].base + view[pick].imm;
	assign mem_req.data		= view[pick].data;
	assign mem_req.rob_idx	= view[pick].rob_idx;

	always_comb begin
		free		= '0;
		free[pick]	= found && mem_ready;	// Transfer frees the entry
	end

	always_ff @(posedge clock) begin
		if (reset)
			stalled <= 1'b0;
		else
			stalled <= found && !mem_ready;
	end

	always_ff @(posedge clock) begin
		stalled_idx <= pick;
	end

endmodule

//--- design/sq_pkg.sv
`include "sq_config.svh"

package sq_pkg;

	localparam int ENTRIES	= `SQ_ENTRIES;
	localparam int SQ_IDX_W	= $clog2(ENTRIES);
	localparam int TAG_W	= $clog2(`PRF_SIZE);
	localparam int ROB_W	= $clog2(`ROB_SIZE) + 1;

	// One operand word, a finished value or a pending register tag
	typedef union packed {
		logic	[63:0]				value;
		struct packed {
			logic	[63-TAG_W:0]	pad;
			logic	[TAG_W-1:0]		tag;
		} tag_view;
	} sq_operand_u;

	typedef struct packed {
		logic					valid;
		logic	[ROB_W-1:0]		rob_idx;
		logic	[63:0]			imm;
		sq_operand_u			base;
		logic					base_ready;
		sq_operand_u			data;
		logic					data_ready;
	} sq_dispatch_t;

	typedef struct packed {
		logic					valid;
		logic	[TAG_W-1:0]		tag;
		logic	[63:0]			value;
	} sq_cdb_t;

	typedef struct packed {
		logic					busy;
		logic					ready;		// Busy with both operands known
		logic	[ROB_W-1:0]		rob_idx;
		logic	[63:0]			imm;
		logic	[63:0]			base;
		logic	[63:0]			data;
	} sq_entry_view_t;

	typedef struct packed {
		logic	[63:0]			addr;
		logic	[63:0]			data;
		logic	[ROB_W-1:0]		rob_idx;
	} sq_mem_req_t;

endpackage

//--- design/store_queue.sv
`timescale 1ns/100ps
`include "sq_config.svh"

module store_queue import sq_pkg::*; (
	input							clock,
	input							reset,
	input							flush,
	input	sq_dispatch_t			dispatch [2],
	input	sq_cdb_t				cdb [2],
	input							mem_ready,
	output logic					room,
	output logic					mem_valid,
	output	sq_mem_req_t			mem_req
);

	logic	[`SQ_ENTRIES-1:0]		busy;
	logic	[`SQ_ENTRIES-1:0]		write;
	logic	[`SQ_ENTRIES-1:0]		free;
	sq_dispatch_t					write_payload [`SQ_ENTRIES];
	sq_entry_view_t					view [`SQ_ENTRIES];

	sq_dispatch dispatcher (
		.clock			(clock),
		.reset			(reset),
		.flush			(flush),
		.dispatch		(dispatch),
		.busy			(busy),
		.free			(free),
		.write			(write),
		.write_payload	(write_payload),
		.room			(room)
	);

	for (genvar i = 0; i < `SQ_ENTRIES; i++) begin : g_entry
		sq_entry entry (
			.clock			(clock),
			.reset			(reset),
			.flush			(flush),
			.write			(write[i]),
			.write_payload	(write_payload[i]),
			.free			(free[i]),
			.cdb			(cdb),
			.view			(view[i])
		);

		assign busy[i] = view[i].busy;
	end

	sq_issue picker (
		.clock			(clock),
		.reset			(reset),
		.view			(view),
		.mem_ready		(mem_ready),
		.mem_valid		(mem_valid),
		.mem_req		(mem_req),
		.free			(free)
	);

endmodule

//--- run.sh
#!/bin/sh
# Compile and run the store queue testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module store_queue_tb -f build.f -o store_queue_sim &&
./obj_dir/store_queue_sim | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "Simulation run passed" ||
{ echo "Simulation run failed"; exit 1; }

//--- testbench/store_queue_tb.sv
`timescale 1ns/100ps
`include "sq_config.svh"

module store_queue_tb import sq_pkg::*; ();

	localparam int DEPTH		= `SQ_ENTRIES;
	localparam int TAGS			= `PRF_SIZE;
	localparam int ROBS			= 1 << ROB_W;
	localparam int DRAIN_LIMIT	= 400;

	logic					clock;
	logic					reset;
	logic					flush;
	logic					mem_ready;
	sq_dispatch_t			dispatch [2];
	sq_cdb_t				cdb [2];
	logic					room;
	logic					mem_valid;
	sq_mem_req_t			mem_req;

	// Reference model indexed by rob index
	logic	[ROBS-1:0]		out_valid;
	logic	[ROBS-1:0]		base_known;
	logic	[ROBS-1:0]		data_known;
	logic	[TAG_W-1:0]		base_tag [ROBS];
	logic	[TAG_W-1:0]		data_tag [ROBS];
	logic	[63:0]			base_val [ROBS];
	logic	[63:0]			data_val [ROBS];
	logic	[63:0]			imm_val [ROBS];
	logic	[TAGS-1:0]		tag_pend;		// Tags not yet broadcast
	logic	[DEPTH-1:0]		slot_busy;		// Model of the entry array
	logic	[ROB_W-1:0]		slot_rob [DEPTH];
	logic	[ROBS-1:0]		shown_ready;	// Ready as the entries show it this cycle
	logic	[ROB_W-1:0]		rob_next;
	int						occupied;		// Busy entries in the current cycle
	int						n_disp;
	int						stall_left;
	int						held_slot;
	logic					held_valid;
	logic					after_flush;
	sq_mem_req_t			held_req;
	logic	[31:0]			lfsr;

	store_queue UUT (
		.clock		(clock),
		.reset		(reset),
		.flush		(flush),
		.dispatch	(dispatch),
		.cdb		(cdb),
		.mem_ready	(mem_ready),
		.room		(room),
		.mem_valid	(mem_valid),
		.mem_req	(mem_req)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
	function automatic logic [63:0] next_bits(input int n);
		logic	[63:0]	bits;
		bits = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			bits = {bits[62:0], lfsr[0]};
		end
		return bits;
	endfunction

	function automatic logic chance(input int eighths);
		return int'(next_bits(3)) < eighths;
	endfunction

	task automatic report_failure(input string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic compare_req(input sq_mem_req_t got, input sq_mem_req_t exp);
		if (got.addr !== exp.addr)
			report_failure($sformatf("ERR mem_req.addr got %h expected %h", got.addr, exp.addr));
		else if (got.data !== exp.data)
			report_failure($sformatf("ERR mem_req.data got %h expected %h", got.data, exp.data));
		else if (got.rob_idx !== exp.rob_idx)
			report_failure($sformatf("ERR mem_req.rob_idx got %h expected %h",
				got.rob_idx, exp.rob_idx));
	endtask

	task automatic compare_room(input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("ERR room got %h expected %h", got, exp));
	endtask

	task automatic compare_valid(input logic got, input logic exp);
		if (got !== exp)
			report_failure($sformatf("ERR mem_valid got %h expected %h", got, exp));
	endtask

	task automatic pick_tag(input logic want, output logic ok, output logic [TAG_W-1:0] tag);
		int		start;
		start	= int'(next_bits(TAG_W));
		ok		= 1'b0;
		tag		= '0;
		for (int i = 0; i < TAGS; i++) begin
			if (!ok && tag_pend[TAG_W'(start + i)] == want) begin
				ok	= 1'b1;
				tag	= TAG_W'(start + i);
			end
		end
	endtask

	// Broadcast value becomes the operand of every store waiting on the tag
	task automatic resolve_tag(input logic [TAG_W-1:0] tag, input logic [63:0] value);
		for (int r = 0; r < ROBS; r++) begin
			if (out_valid[r] && !base_known[r] && base_tag[r] == tag) begin
				base_known[r]	= 1'b1;
				base_val[r]		= value;
			end
			if (out_valid[r] && !data_known[r] && data_tag[r] == tag) begin
				data_known[r]	= 1'b1;
				data_val[r]		= value;
			end
		end
		tag_pend[tag] = 1'b0;
	endtask

	task automatic draw_operand(input logic track, input int tag_odds,
			output sq_operand_u op, output logic ready);
		logic					ok;
		logic	[TAG_W-1:0]		tag;
		op.value	= next_bits(64);
		ready		= 1'b1;
		if (track && chance(tag_odds)) begin
			ok = 1'b0;
			if (chance(2))
				pick_tag(1'b1, ok, tag);		// Share a tag another store waits on
			if (!ok)
				pick_tag(1'b0, ok, tag);
			op.tag_view.tag	= tag;				// Pad bits stay random
			tag_pend[tag]	= 1'b1;
			ready			= 1'b0;
		end
	endtask

	task automatic build_store(input logic valid, input logic track, input int tag_odds,
			output sq_dispatch_t d);
		sq_operand_u			base_op;
		sq_operand_u			data_op;
		logic					base_rdy;
		logic					data_rdy;
		logic					found;
		logic	[ROB_W-1:0]		r;
		draw_operand(valid && track, tag_odds, base_op, base_rdy);
		draw_operand(valid && track, tag_odds, data_op, data_rdy);
		d.valid			= valid;
		d.rob_idx		= ROB_W'(next_bits(ROB_W));
		d.imm			= next_bits(64);
		d.base			= base_op;
		d.base_ready	= base_rdy;
		d.data			= data_op;
		d.data_ready	= data_rdy;
		if (valid && track) begin
			found	= 1'b0;
			r		= rob_next;
			for (int i = 0; i < ROBS; i++) begin
				if (!found && !out_valid[ROB_W'(int'(rob_next) + i)]) begin
					found	= 1'b1;
					r		= ROB_W'(int'(rob_next) + i);
				end
			end
			rob_next		= r + 1'b1;
			d.rob_idx		= r;
			out_valid[r]	= 1'b1;
			imm_val[r]		= d.imm;
			base_known[r]	= base_rdy;
			base_val[r]		= base_op.value;
			base_tag[r]		= base_op.tag_view.tag;
			data_known[r]	= data_rdy;
			data_val[r]		= data_op.value;
			data_tag[r]		= data_op.tag_view.tag;
			n_disp			= n_disp + 1;
			found			= 1'b0;
			for (int e = 0; e < DEPTH; e++) begin
				if (!found && !slot_busy[e]) begin
					found			= 1'b1;		// Lowest free entry takes the store
					slot_busy[e]	= 1'b1;
					slot_rob[e]		= r;
				end
			end
		end
	endtask

	task automatic plan_cdbs(input int cdb_odds, output sq_cdb_t c0, output sq_cdb_t c1);
		logic					ok;
		logic	[TAG_W-1:0]		tag;
		c0.valid	= 1'b0;
		c0.tag		= TAG_W'(next_bits(TAG_W));
		c0.value	= next_bits(64);
		c1.valid	= 1'b0;
		c1.tag		= TAG_W'(next_bits(TAG_W));
		c1.value	= next_bits(64);
		if (chance(cdb_odds)) begin
			pick_tag(1'b1, ok, tag);
			if (ok) begin
				c1.valid	= 1'b1;
				c1.tag		= tag;
				resolve_tag(tag, c1.value);
				if (chance(2)) begin
					c0.valid	= 1'b1;		// Same tag on both buses so the CDB 1 value counts
					c0.tag		= tag;
				end
			end
		end
		if (!c0.valid && chance(cdb_odds)) begin
			pick_tag(1'b1, ok, tag);
			if (ok) begin
				c0.valid	= 1'b1;
				c0.tag		= tag;
				resolve_tag(tag, c0.value);
			end
		end
	endtask

	task automatic observe_cycle();
		sq_mem_req_t			exp;
		logic					exp_valid;
		logic	[ROB_W-1:0]		r;
		int						e;
		compare_room(room, (DEPTH - occupied) >= 2);
		if (after_flush && mem_valid)
			report_failure("mem_valid is high in the cycle after a flush");
		if (held_valid && !mem_valid)
			report_failure("mem_valid fell before memory accepted the request");
		// A refused request keeps its entry ahead of the lowest ready one
		exp_valid	= held_valid;
		e			= held_slot;
		for (int i = DEPTH - 1; i >= 0; i--) begin
			if (!held_valid && slot_busy[i] && shown_ready[slot_rob[i]]) begin
				exp_valid	= 1'b1;
				e			= i;
			end
		end
		r = slot_rob[e];
		compare_valid(mem_valid, exp_valid);
		if (held_valid)
			compare_req(mem_req, held_req);
		if (exp_valid) begin
			exp.addr	= base_val[r] + imm_val[r];
			exp.data	= data_val[r];
			exp.rob_idx	= r;
			compare_req(mem_req, exp);
			if (mem_ready) begin
				out_valid[r]	= 1'b0;		// Transfer at the coming edge
				slot_busy[e]	= 1'b0;
				occupied		= occupied - 1;
			end
		end
		held_valid	= exp_valid && !mem_ready && !flush;
		held_slot	= e;
		held_req	= mem_req;
		after_flush	= flush;
		occupied	= occupied + n_disp;
		if (flush) begin
			out_valid	= '0;
			tag_pend	= '0;
			slot_busy	= '0;
			occupied	= 0;
		end
		shown_ready = out_valid & base_known & data_known;	// Entry ready bits next cycle
	endtask

	// One clock cycle of random stimulus followed by its checks
	task automatic step(input int tag_odds, input int cdb_odds, input int disp_odds,
			input logic stalls, input logic flushes);
		sq_dispatch_t	d0;
		sq_dispatch_t	d1;
		sq_cdb_t		c0;
		sq_cdb_t		c1;
		logic			go_flush;
		logic			has_room;
		logic			ready;
		go_flush	= flushes && chance(1) && chance(1);
		has_room	= (DEPTH - occupied) >= 2;		// Matches room next cycle
		if (stall_left == 0 && stalls && chance(1))
			stall_left = int'(next_bits(4)) + 1;
		ready = stall_left == 0 && !go_flush;
		if (stall_left != 0)
			stall_left = stall_left - 1;
		n_disp = 0;
		plan_cdbs(go_flush ? 0 : cdb_odds, c0, c1);
		build_store(has_room && chance(disp_odds), !go_flush, tag_odds, d0);
		build_store(has_room && chance(disp_odds), !go_flush, tag_odds, d1);
		@(posedge clock);
		flush		<= go_flush;
		mem_ready	<= ready;
		dispatch[0]	<= d0;
		dispatch[1]	<= d1;
		cdb[0]		<= c0;
		cdb[1]		<= c1;
		@(negedge clock);
		observe_cycle();
	endtask

	initial begin
		int		waited;
		lfsr		= 32'hab75_9cb9;
		reset		<= 1'b1;
		flush		<= 1'b0;
		mem_ready	<= 1'b0;
		dispatch[0]	<= '0;
		dispatch[1]	<= '0;
		cdb[0]		<= '0;
		cdb[1]		<= '0;
		out_valid	= '0;
		tag_pend	= '0;
		slot_busy	= '0;
		shown_ready	= '0;
		rob_next	= '0;
		occupied	= 0;
		n_disp		= 0;
		stall_left	= 0;
		held_slot	= 0;
		held_valid	= 1'b0;
		after_flush	= 1'b0;
		held_req	= '0;
		repeat (8) @(posedge clock);
		reset <= 1'b0;
		@(negedge clock);
		if (mem_valid !== 1'b0)
			report_failure("mem_valid is high after reset");
		compare_room(room, 1'b1);
		repeat (300) step(0, 0, 6, 1'b0, 1'b0);		// Ready operands only
		repeat (400) step(5, 4, 5, 1'b0, 1'b0);		// Tag wakeup from the CDBs
		repeat (400) step(3, 4, 7, 1'b1, 1'b0);		// Memory back-pressure
		repeat (400) step(4, 3, 5, 1'b0, 1'b1);
		repeat (3000) step(4, 4, 5, 1'b1, 1'b1);	// Everything mixed
		waited = 0;
		while (out_valid != '0) begin
			if (waited == DRAIN_LIMIT)
				report_failure("stores still outstanding when the drain timeout expired");
			step(0, 8, 0, 1'b0, 1'b0);
			waited = waited + 1;
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule
